//--- int_div_golden.txt
# fn (0 unsigned, 1 signed)  dividend  divisor  expected {rem, quot}
# all fields hex
0 00000064 00000007 000000020000000e
0 ffffffff 00000010 0000000f0fffffff
0 12345678 00000001 0000000012345678
0 00000005 0000000a 0000000500000000
0 80000000 ffffffff 8000000000000000
0 deadbeef 00000000 deadbeefffffffff
0 fffffff9 00000002 000000017ffffffc
0 00000000 00000005 0000000000000000
0 0000abcd 0000abcd 0000000000000001
1 00000064 00000007 000000020000000e
1 ffffff9c 00000007 fffffffefffffff2
1 00000064 fffffff9 00000002fffffff2
1 ffffff9c fffffff9 fffffffe0000000e
1 80000000 ffffffff 0000000080000000
1 00000064 00000000 00000064ffffffff
1 ffffff9c 00000000 ffffff9c00000001
1 80000000 00000001 0000000080000000
1 7fffffff 00000002 000000013fffffff
1 fffffff9 00000002 fffffffffffffffd
1 80000000 00000003 fffffffed5555556
1 00000007 ffffff9c 0000000700000000

//--- int_div.f
div_msg_pkg.sv
div_ctrl_pkg.sv
int_div_dpath.sv
int_div_ctrl.sv
int_div_iterative.sv
int_div_tb.sv

//--- Bender.yml
package:
  name: int_div

sources:
  - div_msg_pkg.sv
  - div_ctrl_pkg.sv
  - int_div_dpath.sv
  - int_div_ctrl.sv
  - int_div_iterative.sv
  - target: simulation
    files:
      - int_div_tb.sv

//--- int_div_tb.sv
/*
 * testbench for the iterative divider
 * golden vectors, random request gaps and response back-pressure
 */

`timescale 1ns/1ns

module int_div_tb
  import div_msg_pkg::*;
();

  // accepting edge plus one edge per step
  localparam int latency_edges = 1 + div_width;
  // per vector budget, latency plus gap plus back-pressure slack
  localparam int cycles_per_vec = 33 + 3 + 16;

  logic      clk;
  logic      reset;
  div_req_t  req;
  logic      req_val;
  logic      req_rdy;
  div_resp_t resp;
  logic      resp_val;
  logic      resp_rdy;

  int_div_iterative i_dut (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  div_req_t    vec_req[$];
  div_resp_t   vec_exp[$];
  int          n_vec;
  int          mismatch_errors;
  int          other_errors;
  int          accept_count;
  int          resp_count;
  int          cycle_count;
  int          cycle_limit;
  logic        checking;
  logic [31:0] gap_rng;
  logic [31:0] rdy_rng;
  // DUT outputs as seen on the last falling edge
  logic        s_req_rdy;
  logic        s_resp_val;
  div_resp_t   s_resp;
  // transfers on the last rising edge
  logic        acc_seen;
  logic        xfer_seen;
  // operation accepted, response not yet valid
  logic        waiting;
  // response valid, not yet taken
  logic        holding;
  int          edges;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] got_v);
    mismatch_errors++;
    $display("mismatch at %0t: %s expected %h got %h", $time, name, exp_v, got_v);
  endtask

  task automatic report_failure(input string what);
    other_errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------
  // timeout
  // ----------------------------------------

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      report_failure("timeout, run did not finish in time");
      $display("errors: %0d mismatch, %0d other", mismatch_errors, other_errors);
      $display("Simulation failed");
      $finish;
    end
  end

  // inputs are stable here, outputs come from the falling edge samples
  always @(posedge clk) begin
    acc_seen  = !reset && req_val && s_req_rdy;
    xfer_seen = !reset && s_resp_val && resp_rdy;
  end

  // ----------------------------------------
  // response monitor
  // ----------------------------------------

  always @(negedge clk) begin
    if (checking) begin
      if (acc_seen) begin
        accept_count++;
        assert (!waiting && !holding) else report_failure("request accepted while busy");
        waiting = 1'b1;
        edges   = 1;
      end else if (waiting) begin
        edges++;
      end
      if (xfer_seen) begin
        assert (resp_count < n_vec) else report_failure("more responses than vectors");
        if (resp_count < n_vec) begin
          assert (s_resp == vec_exp[resp_count])
            else report_mismatch("resp", vec_exp[resp_count], s_resp);
        end
        resp_count++;
        holding = 1'b0;
        assert (resp_val == 1'b0) else report_mismatch("resp_val", 0, resp_val);
      end else if (holding) begin
        // back-pressure, response frozen
        assert (resp_val == 1'b1) else report_mismatch("resp_val", 1, resp_val);
        assert (resp == s_resp) else report_mismatch("resp", s_resp, resp);
      end
      if (resp_val && !holding) begin
        assert (waiting) else report_failure("response valid with no request in flight");
        if (waiting) begin
          assert (edges == latency_edges)
            else report_mismatch("resp_val latency", latency_edges, edges);
        end
        waiting = 1'b0;
        holding = 1'b1;
      end
      // ready only when nothing is in flight
      assert (req_rdy == !(waiting || holding))
        else report_mismatch("req_rdy", !(waiting || holding), req_rdy);
    end
    s_req_rdy  = req_rdy;
    s_resp_val = resp_val;
    s_resp     = resp;
    rdy_rng    = xorshift32(rdy_rng);
    resp_rdy   = rdy_rng[7];
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------

  initial begin
    int               fd;
    int               n_read;
    int               gap;
    logic [3:0]       fn_val;
    logic [31:0]      a_val;
    logic [31:0]      b_val;
    logic [63:0]      exp_val;
    logic [8*128-1:0] line_buf;
    div_req_t         r;

    reset = 1'b1;
    req = '0;
    req_val = 1'b0;
    resp_rdy = 1'b0;
    mismatch_errors = 0;
    other_errors = 0;
    accept_count = 0;
    resp_count = 0;
    cycle_count = 0;
    cycle_limit = 0;
    checking = 1'b0;
    waiting = 1'b0;
    holding = 1'b0;
    edges = 0;
    acc_seen = 1'b0;
    xfer_seen = 1'b0;
    s_req_rdy = 1'b0;
    s_resp_val = 1'b0;
    s_resp = '0;
    gap_rng = 32'd22015;
    // second stream, complement of the seed
    rdy_rng = ~32'd22015;

    fd = $fopen("int_div_golden.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open int_div_golden.txt");
    end else begin
      while (!$feof(fd)) begin
        line_buf = '0;
        if ($fgets(line_buf, fd) > 0) begin
          // comment lines do not parse as four hex fields
          n_read = $sscanf(line_buf, "%h %h %h %h", fn_val, a_val, b_val, exp_val);
          if (n_read == 4) begin
            r.fn = div_fn_e'(fn_val[0]);
            r.a = a_val;
            r.b = b_val;
            vec_req.push_back(r);
            vec_exp.push_back(exp_val);
          end
        end
      end
      $fclose(fd);
    end
    n_vec = vec_req.size();
    assert (n_vec > 0) else report_failure("no golden vectors read");
    cycle_limit = n_vec * cycles_per_vec + 100;

    repeat (8) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    assert (req_rdy == 1'b1) else report_mismatch("req_rdy", 1, req_rdy);
    assert (resp_val == 1'b0) else report_mismatch("resp_val", 0, resp_val);
    checking = 1'b1;

    for (int i = 0; i < n_vec; i++) begin
      gap_rng = xorshift32(gap_rng);
      gap = gap_rng[1:0];
      repeat (gap) @(negedge clk);
      req     = vec_req[i];
      req_val = 1'b1;
      wait (accept_count == i + 1);
      // keep offering while busy, the DUT must not take it again
      gap_rng = xorshift32(gap_rng);
      gap = gap_rng[1:0];
      repeat (gap) @(negedge clk);
      req_val = 1'b0;
      wait (resp_count == i + 1);
    end

    repeat (4) @(negedge clk);
    assert (accept_count == n_vec) else report_failure("request count differs from vectors");
    assert (resp_count == n_vec) else report_failure("response count differs from vectors");
    $display("errors: %0d mismatch, %0d other", mismatch_errors, other_errors);
    if (mismatch_errors == 0 && other_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- int_div_iterative.sv
/*
 * iterative integer divider top
 * joins control and datapath behind val/rdy request and response ports
 */

`timescale 1ns/1ns

module int_div_iterative
  import div_msg_pkg::*, div_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  // request side
  input  div_req_t  req,
  input  logic      req_val,
  output logic      req_rdy,

  // response side
  output div_resp_t resp,
  output logic      resp_val,
  input  logic      resp_rdy
);

  // control to datapath strobes
  div_ctrl_t ctrl;

  // ----------------------------------------
  // control
  // ----------------------------------------

  int_div_ctrl i_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .ctrl     (ctrl)
  );

  // ----------------------------------------
  // datapath
  // ----------------------------------------

  // payload only, no handshake here
  int_div_dpath i_dpath (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .ctrl  (ctrl),
    .resp  (resp)
  );

endmodule

//--- int_div_ctrl.sv
/*
 * iterative divider control
 * FSM and step counter, sequences one division and the val/rdy handshake
 */

`timescale 1ns/1ns

module int_div_ctrl
  import div_msg_pkg::*, div_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  // request handshake
  input  logic      req_val,
  output logic      req_rdy,

  // response handshake
  output logic      resp_val,
  input  logic      resp_rdy,

  // strobes to datapath
  output div_ctrl_t ctrl
);

  // ----------------------------------------
  // step counter sizing
  // ----------------------------------------

  // one step per operand bit
  localparam int cnt_width = $clog2(div_width);

  // first count, counts down to zero
  localparam logic [cnt_width-1:0] cnt_last = cnt_width'(div_width - 1);

  // ----------------------------------------
  // state
  // ----------------------------------------

  div_state_e           state_q;
  div_state_e           state_d;
  logic [cnt_width-1:0] cnt_q;

  // ----------------------------------------
  // handshake decode
  // ----------------------------------------

  logic req_go;
  logic resp_go;
  logic last_step;

  // only one operation in flight
  assign req_rdy  = (state_q == st_idle);
  assign resp_val = (state_q == st_done);

  // transfers
  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // counter at zero during calc
  assign last_step = (state_q == st_calc) && (cnt_q == '0);

  // ----------------------------------------
  // strobes
  // ----------------------------------------

  assign ctrl.operand_load = req_go;
  assign ctrl.step_en      = (state_q == st_calc);
  // final step and result capture share an edge
  assign ctrl.result_load  = last_step;

  // ----------------------------------------
  // next state
  // ----------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (req_go) begin
          state_d = st_calc;
        end
      end
      st_calc: begin
        if (last_step) begin
          state_d = st_done;
        end
      end
      st_done: begin
        // held here under back-pressure
        if (resp_go) begin
          state_d = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  // ----------------------------------------
  // registers
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= st_idle;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      // reload on accept, count down while stepping
      if (req_go) begin
        cnt_q <= cnt_last;
      end else if (ctrl.step_en) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

//--- int_div_dpath.sv
/*
 * iterative divider datapath
 * restoring shift-subtract on operand magnitudes, then sign correction
 */

`timescale 1ns/1ns

module int_div_dpath
  import div_msg_pkg::*, div_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  // request payload, valid while operand_load is high
  input  div_req_t  req,

  // strobes from control
  input  div_ctrl_t ctrl,

  // held stable from result_load until the next one
  output div_resp_t resp
);

  // ----------------------------------------
  // state
  // ----------------------------------------

  // function of the operation in flight
  div_fn_e              fn_q;

  // raw operand sign bits
  logic                 sign_a_q;
  logic                 sign_b_q;

  // divisor magnitude
  logic [div_width-1:0] divisor_q;

  // working register
  // upper div_width+1 bits partial remainder, lower div_width bits quotient
  logic [2*div_width:0] work_q;

  // result register
  div_resp_t            result_q;

  // ----------------------------------------
  // magnitude conversion
  // ----------------------------------------

  logic                 req_signed;
  logic [div_width-1:0] mag_a;
  logic [div_width-1:0] mag_b;

  assign req_signed = (req.fn == div_fn_signed);

  // two's complement only for negative signed operands
  // unsigned operands pass straight through
  assign mag_a = (req_signed && req.a[div_width-1]) ? (~req.a + 1'b1) : req.a;
  assign mag_b = (req_signed && req.b[div_width-1]) ? (~req.b + 1'b1) : req.b;

  // ----------------------------------------
  // shift-subtract step
  // ----------------------------------------

  logic [2*div_width:0] work_shift;
  logic [div_width:0]   diff;
  logic                 diff_neg;
  logic [2*div_width:0] work_next;

  // shift whole register left by one, zero into quotient lsb
  assign work_shift = {work_q[2*div_width-1:0], 1'b0};

  // trial subtract on the remainder half
  assign diff = work_shift[2*div_width:div_width] - {1'b0, divisor_q};

  // remainder after shift is below twice the divisor,
  // so the top bit of diff is a valid sign
  assign diff_neg = diff[div_width];

  always_comb begin
    if (diff_neg) begin
      // restore, quotient bit stays 0
      work_next = work_shift;
    end else begin
      // keep difference, quotient bit 1
      work_next = {diff, work_shift[div_width-1:1], 1'b1};
    end
  end

  // ----------------------------------------
  // sign correction
  // ----------------------------------------

  logic                 fn_signed;
  logic                 neg_quot;
  logic                 neg_rem;
  logic [div_width-1:0] quot_mag;
  logic [div_width-1:0] rem_mag;
  div_resp_t            result_next;

  assign fn_signed = (fn_q == div_fn_signed);

  // quotient negative when signs differ
  assign neg_quot = fn_signed && (sign_a_q ^ sign_b_q);

  // remainder takes the sign of the dividend
  assign neg_rem = fn_signed && sign_a_q;

  // results of the final step, taken from work_next
  assign quot_mag = work_next[div_width-1:0];
  assign rem_mag  = work_next[2*div_width-1:div_width];

  // 0x80000000 / -1 wraps back to 0x80000000 here
  assign result_next.quot = neg_quot ? (~quot_mag + 1'b1) : quot_mag;
  assign result_next.rem  = neg_rem  ? (~rem_mag + 1'b1)  : rem_mag;

  // ----------------------------------------
  // registers
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      fn_q      <= div_fn_unsigned;
      sign_a_q  <= 1'b0;
      sign_b_q  <= 1'b0;
      divisor_q <= '0;
      work_q    <= '0;
      result_q  <= '0;
    end else begin
      // new operation
      if (ctrl.operand_load) begin
        fn_q      <= req.fn;
        sign_a_q  <= req.a[div_width-1];
        sign_b_q  <= req.b[div_width-1];
        divisor_q <= mag_b;
        work_q    <= {{(div_width+1){1'b0}}, mag_a};
      end else if (ctrl.step_en) begin
        work_q <= work_next;
      end

      // last step edge, same cycle as the final step_en
      if (ctrl.result_load) begin
        result_q <= result_next;
      end
    end
  end

  // response comes straight from the result register
  assign resp = result_q;

endmodule

//--- div_ctrl_pkg.sv
/*
 * divider control types
 * FSM states and the strobes sent from control to datapath
 */

package div_ctrl_pkg;

  // ----------------------------------------
  // FSM states
  // ----------------------------------------

  // idle   waiting for a request
  // calc   one shift-subtract step per cycle
  // done   holding the response until taken
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } div_state_e;

  // ----------------------------------------
  // control to datapath
  // ----------------------------------------

  // all strobes are single-cycle, active high
  typedef struct packed {
    // capture request, set up magnitudes
    logic operand_load;
    // one shift-subtract step
    logic step_en;
    // latch sign-corrected result
    logic result_load;
  } div_ctrl_t;

endpackage

//--- div_msg_pkg.sv
/*
 * divider message types
 * request and response layouts plus the divide function encoding
 */

package div_msg_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------

  // operand width, the whole design follows from this
  localparam int div_width = 32;

  // ----------------------------------------
  // function encoding
  // ----------------------------------------

  // one bit on the wire
  typedef enum logic {
    div_fn_unsigned = 1'b0,
    div_fn_signed   = 1'b1
  } div_fn_e;

  // ----------------------------------------
  // messages
  // ----------------------------------------

  // request, 65 bits
  typedef struct packed {
    div_fn_e              fn;
    logic [div_width-1:0] a;    // dividend
    logic [div_width-1:0] b;    // divisor
  } div_req_t;

  // response, 64 bits, remainder in the upper half
  typedef struct packed {
    logic [div_width-1:0] rem;
    logic [div_width-1:0] quot;
  } div_resp_t;

endpackage
